//--- hdl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// feature-map fetch sizes
////////////////////////////////////////////////////////////////////////////

// byte address into the feature-map sram, msb picks the port
`define FMEM_ADDR_WIDTH 16

`define ROWS_PER_GROUP 8     // one row per clock, eight per group

`define FMEM_WORD_BYTES 8    // 64-bit sram word

`define FIFO_DATA_WIDTH 128  // one fifo entry

`endif

//--- hdl/fetch_cfg_pkg.sv
`include "fetch_consts.svh"

package fetch_cfg_pkg;

    // layer configuration, stable while a layer is fetched
    typedef struct packed {
        logic                        input_mode;  // 1 = input layer
        logic [15:0]                 ch_count;    // channel groups per kernel-width step
        logic [3:0]                  kw_count;    // kernel width
        logic [15:0]                 h_count;
        logic [15:0]                 w_count;
        logic [9:0]                  k_count;
        logic [`FMEM_ADDR_WIDTH-1:0] w_offset;    // step per kernel-width position
        logic [`FMEM_ADDR_WIDTH-1:0] h_stride;    // step per window in h
        logic [`FMEM_ADDR_WIDTH-1:0] w_stride;    // step per window in w
    } fetch_cfg_t;

    // loop state, one cycle per row
    typedef struct packed {
        logic                                row_active;
        logic [$clog2(`ROWS_PER_GROUP)-1:0] row_idx;
        logic                                group_last;   // row 7 of an active group
        logic                                ch_wrap;      // last channel group
        logic                                window_last;  // last row of the window
        logic                                h_wrap;
        logic                                w_wrap;
        logic                                all_last;     // last row of the last window
    } loop_evt_t;

endpackage

//--- hdl/fetch_mem_pkg.sv
`include "fetch_consts.svh"

package fetch_mem_pkg;

    // sram address, either a flat byte address or port/word/lane
    typedef union packed {
        logic [`FMEM_ADDR_WIDTH-1:0] flat;
        struct packed {
            logic                        port_sel;   // 0 = port 1, 1 = port 2
            logic [`FMEM_ADDR_WIDTH-5:0] word_idx;
            logic [2:0]                  byte_lane;  // byte inside the 64-bit word
        } split;
    } fmem_addr_u;

    // read request on one sram port
    typedef struct packed {
        logic       ren;
        fmem_addr_u addr;
    } fmem_rd_t;

    // write pair for the two line fifos
    typedef struct packed {
        logic                        wen0;
        logic                        wen1;
        logic [`FIFO_DATA_WIDTH-1:0] wd0;
        logic [`FIFO_DATA_WIDTH-1:0] wd1;
    } fifo_wr_t;

endpackage

//--- hdl/fetch_loop_ctrl.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_loop_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,  // load all counters, run first window
    input  logic                      step_i,   // run the next window
    input  fetch_cfg_pkg::fetch_cfg_t cfg_i,
    output fetch_cfg_pkg::loop_evt_t  evt_o
);
    localparam int ROW_W = $clog2(`ROWS_PER_GROUP);

    logic             row_active_q;
    logic [ROW_W-1:0] row_idx_q;
    logic [15:0]      ch_cnt_q;
    logic [3:0]       kw_cnt_q;
    logic [15:0]      h_cnt_q;
    logic [15:0]      w_cnt_q;
    logic [9:0]       k_cnt_q;
    logic             launch;
    logic             group_last;
    logic             ch_wrap;
    logic             window_last;
    logic             h_wrap;
    logic             w_wrap;
    logic             all_last;

    assign launch = start_i | step_i;

    ////////////////////////////////////////////////////////////////////////////
    // boundary strobes, each one qualified by the one below it
    ////////////////////////////////////////////////////////////////////////////
    assign group_last  = row_active_q & (row_idx_q == ROW_W'(`ROWS_PER_GROUP - 1));
    assign ch_wrap     = group_last & (ch_cnt_q == 16'd1);
    assign window_last = ch_wrap & (kw_cnt_q == 4'd1);
    assign h_wrap      = window_last & (h_cnt_q == 16'd1);
    assign w_wrap      = h_wrap & (w_cnt_q == 16'd1);
    assign all_last    = w_wrap & (k_cnt_q == 10'd1);

    // row phase, rises the cycle after launch
    always_ff @(posedge clk) begin
        if (rst) begin
            row_active_q <= 1'b0;
            row_idx_q    <= '0;
        end else if (launch) begin
            row_active_q <= 1'b1;
            row_idx_q    <= '0;
        end else if (row_active_q) begin
            row_idx_q <= row_idx_q + 1'b1;  // wraps to 0 after row 7
            if (window_last) begin
                row_active_q <= 1'b0;
            end
        end
    end

    // down-counters, each reloads on its own wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            ch_cnt_q <= '0;
            kw_cnt_q <= '0;
            h_cnt_q  <= '0;
            w_cnt_q  <= '0;
            k_cnt_q  <= '0;
        end else if (start_i) begin
            ch_cnt_q <= cfg_i.ch_count;
            kw_cnt_q <= cfg_i.kw_count;
            h_cnt_q  <= cfg_i.h_count;
            w_cnt_q  <= cfg_i.w_count;
            k_cnt_q  <= cfg_i.k_count;
        end else begin
            if (group_last)
                ch_cnt_q <= ch_wrap ? cfg_i.ch_count : ch_cnt_q - 16'd1;
            if (ch_wrap)
                kw_cnt_q <= window_last ? cfg_i.kw_count : kw_cnt_q - 4'd1;
            if (window_last)
                h_cnt_q <= h_wrap ? cfg_i.h_count : h_cnt_q - 16'd1;
            if (h_wrap)
                w_cnt_q <= w_wrap ? cfg_i.w_count : w_cnt_q - 16'd1;
            if (w_wrap)
                k_cnt_q <= all_last ? cfg_i.k_count : k_cnt_q - 10'd1;
        end
    end

    always_comb begin
        evt_o.row_active  = row_active_q;
        evt_o.row_idx     = row_idx_q;
        evt_o.group_last  = group_last;
        evt_o.ch_wrap     = ch_wrap;
        evt_o.window_last = window_last;
        evt_o.h_wrap      = h_wrap;
        evt_o.w_wrap      = w_wrap;
        evt_o.all_last    = all_last;
    end

endmodule

//--- hdl/fetch_addr_gen.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_addr_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  logic                      step_i,
    input  fetch_cfg_pkg::fetch_cfg_t cfg_i,
    input  fetch_cfg_pkg::loop_evt_t  evt_i,
    output logic [2:0]                base_idx1_o,   // even entries
    output logic [2:0]                base_idx2_o,   // odd entries
    input  fetch_mem_pkg::fmem_addr_u base_data1_i,
    input  fetch_mem_pkg::fmem_addr_u base_data2_i,
    output fetch_mem_pkg::fmem_rd_t   rd1_o,
    output fetch_mem_pkg::fmem_rd_t   rd2_o,
    output logic [7:0]                lane_o         // {port_sel, hi, lane2, lane1}
);
    import fetch_mem_pkg::*;

    localparam int AW = `FMEM_ADDR_WIDTH;
    localparam logic [AW-1:0] WORD_STEP = AW'(`FMEM_WORD_BYTES);

    fmem_addr_u    base_q [`ROWS_PER_GROUP];
    logic [AW-1:0] ch_ofs_q;
    logic [AW-1:0] kw_ofs_q;
    logic [AW-1:0] h_ofs_q;
    logic [AW-1:0] w_ofs_q;
    logic [AW-1:0] kern_ofs;
    logic [AW-1:0] win_ofs;
    logic          cap_busy_q;
    logic [1:0]    cap_cnt_q;
    logic [1:0]    cap_pair;
    logic          cap_en;
    fmem_addr_u    row_addr;
    fmem_addr_u    pair1_addr;
    fmem_addr_u    pair2_addr;
    fmem_rd_t      rd1_d;
    fmem_rd_t      rd2_d;

    ////////////////////////////////////////////////////////////////////////////
    // base table, two entries per cycle over four cycles
    ////////////////////////////////////////////////////////////////////////////
    assign cap_en   = start_i | step_i | cap_busy_q;
    assign cap_pair = (start_i | step_i) ? 2'd0 : cap_cnt_q;
    assign base_idx1_o = {cap_pair, 1'b0};
    assign base_idx2_o = {cap_pair, 1'b1};
    assign win_ofs = start_i ? '0 : h_ofs_q + w_ofs_q;  // window offset folded into base

    always_ff @(posedge clk) begin
        if (rst) begin
            cap_busy_q <= 1'b0;
            cap_cnt_q  <= '0;
        end else if (start_i || step_i) begin
            cap_busy_q <= 1'b1;
            cap_cnt_q  <= 2'd1;
        end else if (cap_busy_q) begin
            cap_cnt_q <= cap_cnt_q + 2'd1;
            if (cap_cnt_q == 2'd3)
                cap_busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cap_en) begin
            base_q[{cap_pair, 1'b0}].flat <= base_data1_i.flat + win_ofs;
            base_q[{cap_pair, 1'b1}].flat <= base_data2_i.flat + win_ofs;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // offset accumulators
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            ch_ofs_q <= '0;
            kw_ofs_q <= '0;
            h_ofs_q  <= '0;
            w_ofs_q  <= '0;
        end else if (start_i) begin
            ch_ofs_q <= '0;
            kw_ofs_q <= '0;
            h_ofs_q  <= '0;
            w_ofs_q  <= '0;
        end else begin
            if (evt_i.ch_wrap)
                ch_ofs_q <= '0;
            else if (evt_i.group_last)
                ch_ofs_q <= ch_ofs_q + WORD_STEP;  // 8 channels, one byte each
            if (evt_i.window_last)
                kw_ofs_q <= '0;
            else if (evt_i.ch_wrap)
                kw_ofs_q <= kw_ofs_q + cfg_i.w_offset;
            if (evt_i.h_wrap)
                h_ofs_q <= '0;
            else if (evt_i.window_last)
                h_ofs_q <= h_ofs_q + cfg_i.h_stride;
            if (evt_i.w_wrap)
                w_ofs_q <= '0;
            else if (evt_i.h_wrap)
                w_ofs_q <= w_ofs_q + cfg_i.w_stride;
        end
    end

    assign kern_ofs = ch_ofs_q + kw_ofs_q;

    ////////////////////////////////////////////////////////////////////////////
    // read requests
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        row_addr.flat   = base_q[evt_i.row_idx].flat + kern_ofs;
        pair1_addr.flat = base_q[{evt_i.row_idx[2:1], 1'b0}].flat + kern_ofs;
        pair2_addr.flat = base_q[{evt_i.row_idx[2:1], 1'b1}].flat + kern_ofs;
        rd1_d = '0;
        rd2_d = '0;
        if (!cfg_i.input_mode) begin
            // one read per row, msb picks the port
            rd1_d.ren  = evt_i.row_active & ~row_addr.split.port_sel;
            rd2_d.ren  = evt_i.row_active & row_addr.split.port_sel;
            rd1_d.addr = row_addr;
            rd2_d.addr = row_addr;
        end else if (!evt_i.row_idx[0]) begin
            rd1_d.ren  = evt_i.row_active;   // aligned word of the pair
            rd2_d.ren  = evt_i.row_active;
            rd1_d.addr = pair1_addr;
            rd2_d.addr = pair2_addr;
        end else begin
            rd1_d.ren       = evt_i.row_active;  // following word holds the tail
            rd2_d.ren       = evt_i.row_active;
            rd1_d.addr.flat = rd1_o.addr.flat + WORD_STEP;
            rd2_d.addr.flat = rd2_o.addr.flat + WORD_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd1_o.ren <= 1'b0;
            rd2_o.ren <= 1'b0;
        end else begin
            rd1_o <= rd1_d;
            rd2_o <= rd2_d;
        end
    end

    // alignment info travels with the request
    always_ff @(posedge clk) begin
        lane_o <= {row_addr.split.port_sel, evt_i.row_idx[0],
                   rd2_d.addr.split.byte_lane, rd1_d.addr.split.byte_lane};
    end

endmodule

//--- hdl/fetch_line_packer.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_line_packer (
    input  logic                             clk,
    input  logic                             rst,
    input  fetch_cfg_pkg::fetch_cfg_t        cfg_i,
    input  fetch_cfg_pkg::loop_evt_t         evt_i,
    input  logic [7:0]                       lane_i,      // {port_sel, hi, lane2, lane1}
    input  logic [`FMEM_WORD_BYTES*8-1:0]    fmap_rd1_i,
    input  logic [`FMEM_WORD_BYTES*8-1:0]    fmap_rd2_i,
    output fetch_mem_pkg::fifo_wr_t          fifo_o
);
    localparam int WORD_W = `FMEM_WORD_BYTES * 8;
    localparam int FIFO_W = `FIFO_DATA_WIDTH;

    logic [WORD_W-1:0] data1_q;
    logic [WORD_W-1:0] data2_q;
    logic [WORD_W-1:0] line1_q;
    logic [WORD_W-1:0] line2_q;
    logic [7:0]        lane_d1_q;
    logic [7:0]        lane_d2_q;
    logic [2:0]        act_q;       // row valid, one bit per stage
    logic              hi_row;
    logic [WORD_W-1:0] inter_word;
    logic [WORD_W-1:0] gath1;
    logic [WORD_W-1:0] gath2;

    // bytes from the lane upward, moved down to byte 0
    function automatic logic [WORD_W-1:0] align_low(input logic [WORD_W-1:0] word,
                                                    input logic [2:0]        lane);
        return word >> {lane, 3'b000};
    endfunction

    // top bytes come from the low end of the following word
    function automatic logic [WORD_W-1:0] fill_high(input logic [WORD_W-1:0] low,
                                                    input logic [WORD_W-1:0] word,
                                                    input logic [2:0]        lane);
        logic [6:0] shamt;
        shamt = 7'(WORD_W) - {1'b0, lane, 3'b000};  // 64 when aligned, nothing added
        return low | (word << shamt);
    endfunction

    always_ff @(posedge clk) begin
        if (rst)
            act_q <= '0;
        else
            act_q <= {act_q[1:0], evt_i.row_active};
    end

    always_ff @(posedge clk) begin
        data1_q   <= fmap_rd1_i;   // sram data one cycle after ren
        data2_q   <= fmap_rd2_i;
        lane_d1_q <= lane_i;
        lane_d2_q <= lane_d1_q;
    end

    assign hi_row = lane_d2_q[6];

    ////////////////////////////////////////////////////////////////////////////
    // line register, holds the aligned part of an input-layer pair
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!hi_row) begin
            line1_q <= align_low(data1_q, lane_d2_q[2:0]);
            line2_q <= align_low(data2_q, lane_d2_q[5:3]);
        end
    end

    assign inter_word = lane_d2_q[7] ? data2_q : data1_q;
    assign gath1      = fill_high(line1_q, data1_q, lane_d2_q[2:0]);
    assign gath2      = fill_high(line2_q, data2_q, lane_d2_q[5:3]);

    always_comb begin
        if (cfg_i.input_mode) begin
            fifo_o.wen0 = act_q[2] & hi_row;  // only once the pair is complete
            fifo_o.wen1 = act_q[2] & hi_row;
            fifo_o.wd0  = FIFO_W'(gath1);
            fifo_o.wd1  = FIFO_W'(gath2);
        end else begin
            fifo_o.wen0 = act_q[2] & ~hi_row;  // even rows
            fifo_o.wen1 = act_q[2] & hi_row;
            fifo_o.wd0  = FIFO_W'(inter_word);
            fifo_o.wd1  = FIFO_W'(inter_word);
        end
    end

endmodule

//--- hdl/data_fetcher.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module data_fetcher (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start_i,
    input  logic                          step_i,
    input  fetch_cfg_pkg::fetch_cfg_t     cfg_i,
    output logic [2:0]                    base_idx1_o,
    output logic [2:0]                    base_idx2_o,
    input  fetch_mem_pkg::fmem_addr_u     base_data1_i,
    input  fetch_mem_pkg::fmem_addr_u     base_data2_i,
    input  logic [`FMEM_WORD_BYTES*8-1:0] fmap_rd1_i,
    input  logic [`FMEM_WORD_BYTES*8-1:0] fmap_rd2_i,
    output fetch_mem_pkg::fmem_rd_t       rd1_o,
    output fetch_mem_pkg::fmem_rd_t       rd2_o,
    output fetch_mem_pkg::fifo_wr_t       fifo_o,
    output logic                          matrix_done_o
);
    import fetch_cfg_pkg::*;

    loop_evt_t  evt;
    logic [7:0] lane;   // alignment info, addr gen to packer

    fetch_loop_ctrl i_fetch_loop_ctrl (
        .clk     (clk),
        .rst     (rst),
        .start_i (start_i),
        .step_i  (step_i),
        .cfg_i   (cfg_i),
        .evt_o   (evt)
    );

    fetch_addr_gen i_fetch_addr_gen (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .step_i       (step_i),
        .cfg_i        (cfg_i),
        .evt_i        (evt),
        .base_idx1_o  (base_idx1_o),
        .base_idx2_o  (base_idx2_o),
        .base_data1_i (base_data1_i),
        .base_data2_i (base_data2_i),
        .rd1_o        (rd1_o),
        .rd2_o        (rd2_o),
        .lane_o       (lane)
    );

    fetch_line_packer i_fetch_line_packer (
        .clk        (clk),
        .rst        (rst),
        .cfg_i      (cfg_i),
        .evt_i      (evt),
        .lane_i     (lane),
        .fmap_rd1_i (fmap_rd1_i),
        .fmap_rd2_i (fmap_rd2_i),
        .fifo_o     (fifo_o)
    );

    assign matrix_done_o = evt.all_last;  // last row of the last window

endmodule

//--- bench/data_fetcher_chk.sv
`timescale 1ns/1ps

module data_fetcher_chk (
    input logic                      clk,
    input logic                      rst,
    input fetch_cfg_pkg::fetch_cfg_t cfg_i,
    input fetch_mem_pkg::fmem_rd_t   rd1_o,
    input fetch_mem_pkg::fmem_rd_t   rd2_o,
    input fetch_mem_pkg::fifo_wr_t   fifo_o,
    input logic                      matrix_done_o
);
    int fail_cnt = 0;

    // inter-layer rows read one port only
    a_one_port: assert property (@(posedge clk) disable iff (rst)
        !cfg_i.input_mode |-> !(rd1_o.ren && rd2_o.ren))
        else begin
            fail_cnt++;
            $error("both ports read in inter-layer mode");
        end

    a_wen_after_ren: assert property (@(posedge clk) disable iff (rst)
        (fifo_o.wen0 || fifo_o.wen1) |-> $past(rd1_o.ren || rd2_o.ren, 2))
        else begin
            fail_cnt++;
            $error("fifo write without a read two cycles before");
        end

    // the write for the last row lands three cycles after done
    a_done_wen: assert property (@(posedge clk) disable iff (rst)
        matrix_done_o |-> ##3 (fifo_o.wen0 || fifo_o.wen1))
        else begin
            fail_cnt++;
            $error("no fifo write after done");
        end

endmodule

bind data_fetcher data_fetcher_chk i_data_fetcher_chk (
    .clk           (clk),
    .rst           (rst),
    .cfg_i         (cfg_i),
    .rd1_o         (rd1_o),
    .rd2_o         (rd2_o),
    .fifo_o        (fifo_o),
    .matrix_done_o (matrix_done_o)
);

//--- bench/data_fetcher_tb.sv
`timescale 1ns/1ps

module data_fetcher_tb;
    import fetch_cfg_pkg::*;
    import fetch_mem_pkg::*;

    localparam int TEST_WORDS = 25;  // 9 config, 8 bases, 8 group offsets
    localparam int NUM_TESTS  = 2;

    logic        clk;
    logic        rst;
    logic        start_i;
    logic        step_i;
    fetch_cfg_t  cfg;
    logic [2:0]  base_idx1;
    logic [2:0]  base_idx2;
    fmem_addr_u  base_data1;
    fmem_addr_u  base_data2;
    logic [63:0] fmap_rd1;
    logic [63:0] fmap_rd2;
    fmem_rd_t    rd1;
    fmem_rd_t    rd2;
    fifo_wr_t    fifo;
    logic        matrix_done;

    logic [15:0]  pat [0:TEST_WORDS*NUM_TESTS-1];
    logic [15:0]  base_tbl [0:7];
    logic [15:0]  grp_ofs [0:7];
    logic [127:0] exp0_q [$];
    logic [127:0] exp1_q [$];
    logic         par_q [$];
    int           cyc_q [$];
    logic [15:0]  pa1;
    logic [15:0]  pa2;
    logic         started;
    int           cyc;
    int           rows_seen;
    int           wr_seen;
    int           done_cnt;
    int           win_cnt;
    int           win_total;
    int           limit_cycles;

    data_fetcher i_data_fetcher (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_i),
        .step_i        (step_i),
        .cfg_i         (cfg),
        .base_idx1_o   (base_idx1),
        .base_idx2_o   (base_idx2),
        .base_data1_i  (base_data1),
        .base_data2_i  (base_data2),
        .fmap_rd1_i    (fmap_rd1),
        .fmap_rd2_i    (fmap_rd2),
        .rd1_o         (rd1),
        .rd2_o         (rd2),
        .fifo_o        (fifo),
        .matrix_done_o (matrix_done)
    );

    always #10 clk = ~clk;

    assign base_data1.flat = base_tbl[base_idx1];  // table read in the same cycle
    assign base_data2.flat = base_tbl[base_idx2];

    ////////////////////////////////////////////////////////////////////////////
    // reference models
    ////////////////////////////////////////////////////////////////////////////

    // byte b of the aligned word holds the low byte of its address XOR the port
    function automatic logic [63:0] sram_word(input logic [15:0] addr, input int port);
        logic [63:0] w;
        logic [15:0] a;
        a = addr & 16'hfff8;
        for (int b = 0; b < 8; b++)
            w[b*8 +: 8] = 8'(a + 16'(b)) ^ 8'(port);
        return w;
    endfunction

    // eight consecutive bytes from an unaligned address
    function automatic logic [63:0] gather_bytes(input logic [15:0] addr, input int port);
        logic [63:0] w;
        for (int j = 0; j < 8; j++)
            w[j*8 +: 8] = 8'(addr + 16'(j)) ^ 8'(port);
        return w;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    // registered sram returns data one cycle after ren
    always @(posedge clk) begin
        if (rd1.ren)
            fmap_rd1 <= sram_word(rd1.addr.flat, 1);
        if (rd2.ren)
            fmap_rd2 <= sram_word(rd2.addr.flat, 2);
    end

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : monitor
        int          r;
        int          g;
        logic [15:0] ea;
        if (i_data_fetcher.i_data_fetcher_chk.fail_cnt != 0)
            fail_now("An assertion in the bound checker failed");
        if (!rst && !started) begin
            check("rd1_o.ren", rd1.ren, 0);
            check("rd2_o.ren", rd2.ren, 0);
            check("fifo_o.wen", {fifo.wen0, fifo.wen1}, 0);
            check("matrix_done_o", matrix_done, 0);
        end else if (!rst) begin
            if (rd1.ren || rd2.ren) begin
                r = rows_seen % 8;
                g = rows_seen / 8;
                if (!cfg.input_mode) begin
                    ea = base_tbl[r] + grp_ofs[g];
                    check("rd_addr", rd2.ren ? rd2.addr.flat : rd1.addr.flat, ea);
                    check("rd2_o.ren", rd2.ren, ea[15]);  // msb picks the port
                    exp0_q.push_back(128'(sram_word(ea, ea[15] ? 2 : 1)));
                    exp1_q.push_back('0);
                    par_q.push_back(r[0]);
                    cyc_q.push_back(cyc);
                end else if (!r[0]) begin
                    pa1 = base_tbl[r] + grp_ofs[g];
                    pa2 = base_tbl[r + 1] + grp_ofs[g];
                    check("rd1_o.addr", rd1.addr.flat, pa1);
                    check("rd2_o.addr", rd2.addr.flat, pa2);
                    check("rd_both", {rd1.ren, rd2.ren}, 2'b11);
                end else begin
                    check("rd1_o.addr", rd1.addr.flat, pa1 + 16'd8);
                    check("rd2_o.addr", rd2.addr.flat, pa2 + 16'd8);
                    exp0_q.push_back(128'(gather_bytes(pa1, 1)));
                    exp1_q.push_back(128'(gather_bytes(pa2, 2)));
                    par_q.push_back(1'b1);
                    cyc_q.push_back(cyc);
                end
                rows_seen = rows_seen + 1;
            end
            // done comes with the last row, whose read shows up one cycle later
            if (matrix_done) begin
                done_cnt = done_cnt + 1;
                check("done_window", win_cnt, win_total);
                check("done_row", rows_seen, win_total * 8 * cfg.ch_count * cfg.kw_count - 1);
            end
            if (fifo.wen0 || fifo.wen1) begin
                if (cyc_q.size() == 0)
                    fail_now("FIFO write seen with no matching read");
                check("fifo_delay", cyc - cyc_q.pop_front(), 2);
                if (!cfg.input_mode) begin
                    check("fifo_o.wen0", fifo.wen0, !par_q[0]);  // even rows to fifo0
                    check("fifo_o.wen1", fifo.wen1, par_q[0]);
                    check("fifo_o.wd", par_q[0] ? fifo.wd1 : fifo.wd0, exp0_q[0]);
                end else begin
                    check("fifo_o.wen", {fifo.wen0, fifo.wen1}, 2'b11);
                    check("fifo_o.wd0", fifo.wd0, exp0_q[0]);
                    check("fifo_o.wd1", fifo.wd1, exp1_q[0]);
                end
                void'(par_q.pop_front());
                void'(exp0_q.pop_front());
                void'(exp1_q.pop_front());
                wr_seen = wr_seen + 1;
            end
        end
    end

    // loads one test from the pattern table and runs all its windows
    task automatic run_test(input int ti);
        fetch_cfg_t nc;
        int         off;
        int         rows_win;
        int         wr_win;
        off = ti * TEST_WORDS;
        nc.input_mode = pat[off][0];
        nc.ch_count   = pat[off + 1];
        nc.kw_count   = pat[off + 2][3:0];
        nc.h_count    = pat[off + 3];
        nc.w_count    = pat[off + 4];
        nc.k_count    = pat[off + 5][9:0];
        nc.w_offset   = pat[off + 6];
        nc.h_stride   = pat[off + 7];
        nc.w_stride   = pat[off + 8];
        rows_win  = 8 * nc.ch_count * nc.kw_count;
        wr_win    = nc.input_mode ? rows_win / 2 : rows_win;
        win_total = nc.h_count * nc.w_count * nc.k_count;
        rows_seen = 0;
        wr_seen   = 0;
        done_cnt  = 0;
        @(posedge clk);
        cfg <= nc;
        for (int i = 0; i < 8; i++) begin
            base_tbl[i] = pat[off + 9 + i];
            grp_ofs[i]  = pat[off + 17 + i];
        end
        for (int w = 0; w < win_total; w++) begin
            @(posedge clk);
            if (w == 0)
                start_i <= 1'b1;
            else
                step_i <= 1'b1;
            started = 1'b1;
            win_cnt = w + 1;
            @(posedge clk);
            start_i <= 1'b0;
            step_i  <= 1'b0;
            while (rows_seen < (w + 1) * rows_win)
                @(posedge clk);
            while (wr_seen < (w + 1) * wr_win)
                @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check("done_count", done_cnt, 1);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        start_i  = 1'b0;
        step_i   = 1'b0;
        cfg      = '0;
        fmap_rd1 = '0;
        fmap_rd2 = '0;
        started  = 1'b0;
        cyc      = 0;
        win_cnt  = 0;
        for (int i = 0; i < 8; i++) begin
            base_tbl[i] = '0;
            grp_ofs[i]  = '0;
        end
        $readmemh("bench/fetch_patterns.txt", pat);

        // 8 rows per group plus launch and drain slack per window
        limit_cycles = 200;
        for (int t = 0; t < NUM_TESTS; t++)
            limit_cycles += 8 * pat[t*TEST_WORDS+1] * pat[t*TEST_WORDS+2]
                            * (pat[t*TEST_WORDS+3] * pat[t*TEST_WORDS+4]
                            * pat[t*TEST_WORDS+5]) * 2 + 50;
        fork
            begin
                #(limit_cycles * 20);
                $display("Timeout, the run did not finish within %0d cycles", limit_cycles);
                $display("Test failed");
                $fatal(1);
            end
        join_none

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (6) @(posedge clk);  // idle outputs before any start
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        check("assert_failures", data_fetcher_tb.i_data_fetcher.i_data_fetcher_chk.fail_cnt, 0);
        $display("Test passed");
        $finish;
    end

endmodule

//--- bench/fetch_patterns.txt
// per test: mode ch kw h w k w_offset h_stride w_stride, then 8 base addresses,
// then 8 expected group offsets added to the row's base address (hex)

// inter-layer, 2 windows of 4 groups
0000 0002 0002 0002 0001 0001 0040 0100 1000
0010 8021 0132 8243 0354 8465 0576 8687
0000 0008 0040 0048 0100 0108 0140 0148

// input-layer, 1 window of 1 group, unaligned pair addresses
0001 0001 0001 0001 0001 0001 0000 0000 0000
0013 0125 0207 0331 0400 0516 0622 0777
0000 0000 0000 0000 0000 0000 0000 0000

//--- all.f
+incdir+hdl
hdl/fetch_cfg_pkg.sv
hdl/fetch_mem_pkg.sv
hdl/fetch_loop_ctrl.sv
hdl/fetch_addr_gen.sv
hdl/fetch_line_packer.sv
hdl/data_fetcher.sv
bench/data_fetcher_chk.sv
bench/data_fetcher_tb.sv

//--- Bender.yml
package:
  name: data_fetcher

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_cfg_pkg.sv
      - hdl/fetch_mem_pkg.sv
      - hdl/fetch_loop_ctrl.sv
      - hdl/fetch_addr_gen.sv
      - hdl/fetch_line_packer.sv
      - hdl/data_fetcher.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/data_fetcher_chk.sv
      - bench/data_fetcher_tb.sv
